// File: hdl/roc_addr_decode.sv
//******************************
// Stage 1 address decoder with
// external chip selects
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_addr_decode import roc_pkg::*; #(
    parameter logic [15:0] ROM_BASE = ROM_BASE_DEF
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire bus_req_t    bus,
    output dec_t             dec,
    output logic             rom_cs,
    output logic             vram_cs,
    output logic             objram_cs,
    output logic             ram_cs,
    output logic [15:0]      rom_addr
);

    region_e region;
    logic    io_cs;          // I/O page hit for this direction
    logic    vec_win;        // FFF0-FFFD
    logic    rom_hit;
    logic    wr_stb;

    assign io_cs   = bus.vma && bus.addr[15:9] == (bus.rnw ? IO_RD_PAGE : IO_WR_PAGE);
    assign vec_win = bus.addr[15:4] == VEC_BASE[15:4] && !(&bus.addr[3:1]);
    assign rom_hit = bus.vma && bus.addr >= ROM_BASE;
    assign wr_stb  = bus.cen && !bus.rnw;

    // Memory selects go out unregistered so the RAMs answer in time
    assign objram_cs = bus.vma && bus.addr[15:11] == 5'b0100_0;   // 4000-47FF
    assign vram_cs   = bus.vma && bus.addr[15:11] == 5'b0100_1;   // 4800-4FFF
    assign ram_cs    = bus.vma && bus.addr[15:12] == 4'b0101;     // 5000-5FFF
    assign rom_cs    = rom_hit && bus.rnw && !vec_win;
    assign rom_addr  = bus.addr - ROM_BASE;

    always_comb begin
        region = NONE;
        if (io_cs) begin
            // A[8:7] picks the device, direction picks the set
            case ({bus.rnw, bus.addr[8:7]})
                3'b1_00: region = DIP1;
                3'b1_01: region = IMUX;
                3'b1_10: region = DIP3;
                3'b1_11: region = VEC;
                3'b0_01: region = OREG;
                3'b0_10: region = SND;
                3'b0_11: region = VEC;
                default: region = NONE;  // write at page offset 0
            endcase
        end else if (objram_cs) begin
            region = OBJ;
        end else if (vram_cs) begin
            region = VRAM;
        end else if (ram_cs) begin
            region = RAM;
        end else if (rom_hit) begin
            // Vector fetches are served by the vector RAM
            region = (bus.rnw && vec_win) ? VEC : ROM;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec.region <= NONE;
            dec.lo     <= 4'd0;
            dec.wr     <= 1'b0;
            dec.rd     <= 1'b0;
            dec.wdata  <= 8'd0;
        end else begin
            dec.region <= region;
            dec.lo     <= bus.addr[3:0];
            dec.wr     <= wr_stb;
            dec.rd     <= bus.vma && bus.rnw;
            dec.wdata  <= bus.wdata;       // write byte follows its select
        end
    end

endmodule

`default_nettype wire

// File: hdl/roc_ctrl_latch.sv
//******************************
// Stage 2 write path, sound and
// output latches, vector RAM
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_ctrl_latch import roc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire dec_t        dec,
    output logic      [ 7:0] snd_latch,
    output ctrl_t            ctrl,
    output logic      [ 7:0] vec_dout
);

    logic [7:0] vec_mem [0:15];   // interrupt vectors, FFF0-FFFD
    logic       snd_we;
    logic       oreg_we;
    logic       vec_we;
    logic       bit_d;            // latch data is D0 only

    assign snd_we  = dec.wr && dec.region == SND;
    assign oreg_we = dec.wr && dec.region == OREG;
    assign vec_we  = dec.wr && dec.region == VEC;
    assign bit_d   = dec.wdata[0];

    // Sound command byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'd0;
        end else if (snd_we) begin
            snd_latch <= dec.wdata;
        end
    end

    // Addressable latch, one output per A[2:0]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl.flip    <= 1'b0;
            ctrl.snd_on  <= 1'b0;
            ctrl.mute    <= 1'b0;
            ctrl.firq_en <= 1'b0;
            ctrl.irq_en  <= 1'b0;
        end else if (oreg_we) begin
            case (dec.lo[2:0])
                3'd0: ctrl.flip    <= bit_d;
                3'd1: ctrl.snd_on  <= bit_d;
                3'd2: ctrl.mute    <= bit_d;
                // 3 and 4 drive the coin counters, 5 is open
                3'd6: ctrl.firq_en <= bit_d;
                3'd7: ctrl.irq_en  <= bit_d;
                default: ;
            endcase
        end
    end

    // Vector RAM write port
    always_ff @(posedge clk) begin
        if (vec_we) begin
            vec_mem[dec.lo] <= dec.wdata;
        end
    end

    // Async read, registered downstream in the read mux
    assign vec_dout = vec_mem[dec.lo];

endmodule

`default_nettype wire

// File: hdl/roc_irq_gen.sv
//******************************
// VBL edge detect, IRQ and FIRQ
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_irq_gen import roc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  lvbl,
    input  wire logic  dip_pause,
    input  wire ctrl_t ctrl,
    output logic       irq_n,
    output logic       firq_n
);

    logic lvbl_r;        // synchronised LVBL
    logic lvbl_rr;       // previous sample
    logic vbl_fall;
    logic odd_frame;     // FIRQ every second frame

    assign vbl_fall = lvbl_rr && !lvbl_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_r  <= 1'b1;
            lvbl_rr <= 1'b1;
        end else begin
            lvbl_r  <= lvbl;
            lvbl_rr <= lvbl_r;
        end
    end

    // IRQ once per frame while running
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else if (!ctrl.irq_en) begin
            irq_n <= 1'b1;                  // disable acts as ack
        end else if (vbl_fall && dip_pause) begin
            irq_n <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            odd_frame <= 1'b0;
            firq_n    <= 1'b1;
        end else begin
            if (vbl_fall) begin
                odd_frame <= !odd_frame;
                if (!odd_frame) firq_n <= 1'b0;     // even frames only
            end
            // Clear wins over a same-cycle set
            if (!ctrl.firq_en || !dip_pause) firq_n <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/roc_main_bus.sv
//******************************
// Main board bus glue top level
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_main_bus import roc_pkg::*; #(
    parameter logic [15:0] ROM_BASE = ROM_BASE_DEF
) (
    input  wire logic        clk,
    input  wire logic        rst,
    // CPU side
    input  wire bus_req_t    bus,
    output logic      [ 7:0] cpu_din,
    // Program ROM
    output logic      [15:0] rom_addr,
    output logic             rom_cs,
    input  wire logic [ 7:0] rom_data,
    input  wire logic        rom_ok,
    output logic             rom_ok_out,
    // Video and work memories
    output logic             vram_cs,
    output logic             objram_cs,
    output logic             ram_cs,
    input  wire logic [ 7:0] vram_dout,
    input  wire logic [ 7:0] obj_dout,
    input  wire logic [ 7:0] ram_dout,
    // Cabinet and DIPs
    input  wire cab_t        cab,
    input  wire logic [23:0] dipsw,
    input  wire logic        dip_pause,
    // Sound, config, status
    output logic      [ 7:0] snd_latch,
    output ctrl_t            ctrl,
    output logic      [ 7:0] st_dout,
    // Interrupts
    input  wire logic        lvbl,
    output logic             irq_n,
    output logic             firq_n
);

    dec_t       dec;         // stage 1 result, shared by both stage 2 blocks
    logic [7:0] vec_dout;

    assign st_dout    = {3'b000, ctrl.mute, ctrl.snd_on, ctrl.flip,
                         ctrl.firq_en, ctrl.irq_en};
    assign rom_ok_out = rom_ok;    // status only, no wait states

    roc_addr_decode #(
        .ROM_BASE  (ROM_BASE)
    ) decode_i (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .dec       (dec),
        .rom_cs    (rom_cs),
        .vram_cs   (vram_cs),
        .objram_cs (objram_cs),
        .ram_cs    (ram_cs),
        .rom_addr  (rom_addr)
    );

    roc_read_mux read_i (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .rom_data  (rom_data),
        .vram_dout (vram_dout),
        .obj_dout  (obj_dout),
        .ram_dout  (ram_dout),
        .vec_dout  (vec_dout),
        .dipsw     (dipsw),
        .cab       (cab),
        .cpu_din   (cpu_din)
    );

    roc_ctrl_latch latch_i (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .snd_latch (snd_latch),
        .ctrl      (ctrl),
        .vec_dout  (vec_dout)
    );

    // interrupts follow the latch enables
    roc_irq_gen irq_i (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .ctrl      (ctrl),
        .irq_n     (irq_n),
        .firq_n    (firq_n)
    );

endmodule

`default_nettype wire

// File: hdl/roc_pkg.sv
//******************************
// Address map, bus regions and
// bus, decode, latch structs
//******************************
`default_nettype none

package roc_pkg;

    // Program ROM start, overridable at the top
    localparam logic [15:0] ROM_BASE_DEF = 16'h6000;
    // FFF0-FFFD reads come from the vector RAM
    localparam logic [15:0] VEC_BASE     = 16'hfff0;
    // I/O page codes, compared against A[15:9]
    localparam logic [ 6:0] IO_RD_PAGE   = 7'h40;   // 8000-81FF
    localparam logic [ 6:0] IO_WR_PAGE   = 7'h18;   // 3000-31FF

    typedef enum logic [3:0] {
        NONE, ROM, VRAM, OBJ, RAM,
        DIP1, DIP3, IMUX, VEC,      // read side of the I/O page
        SND, OREG                   // write side
    } region_e;

    // One CPU bus cycle as seen on the pins
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic        vma;
        logic        cen;           // CPU clock enable strobe
        logic [ 7:0] wdata;
    } bus_req_t;

    typedef struct packed {
        region_e     region;
        logic [ 3:0] lo;            // A[3:0]
        logic        wr;            // write strobe
        logic        rd;
        logic [ 7:0] wdata;
    } dec_t;

    // 74LS259 outputs in use
    typedef struct packed {
        logic flip;
        logic snd_on;
        logic mute;
        logic firq_en;
        logic irq_en;
    } ctrl_t;

    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [5:0] joy1;           // buttons [5:4], directions [3:0]
        logic [5:0] joy2;
        logic       service;
    } cab_t;

endpackage

`default_nettype wire

// File: hdl/roc_read_mux.sv
//******************************
// Stage 2 read path, cabinet
// formatting and CPU data reg
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_read_mux import roc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire dec_t        dec,
    input  wire logic [ 7:0] rom_data,
    input  wire logic [ 7:0] vram_dout,
    input  wire logic [ 7:0] obj_dout,
    input  wire logic [ 7:0] ram_dout,
    input  wire logic [ 7:0] vec_dout,
    input  wire logic [23:0] dipsw,
    input  wire cab_t        cab,
    output logic      [ 7:0] cpu_din
);

    logic [7:0] cabinet;     // IMUX byte
    logic [7:0] rd_byte;     // byte of the selected region

    // Player byte: two pulled-up bits, buttons, directions as 2,3,0,1
    function automatic logic [7:0] joy_byte(input logic [5:0] joy);
        joy_byte = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    always_comb begin
        case (dec.lo[1:0])
            2'd0:    cabinet = {3'b111, cab.start, cab.service, cab.coin};
            2'd1:    cabinet = joy_byte(cab.joy1);
            2'd2:    cabinet = joy_byte(cab.joy2);
            default: cabinet = dipsw[15:8];     // middle DIP bank
        endcase
    end

    always_comb begin
        case (dec.region)
            ROM:     rd_byte = rom_data;
            VRAM:    rd_byte = vram_dout;
            OBJ:     rd_byte = obj_dout;
            RAM:     rd_byte = ram_dout;
            DIP1:    rd_byte = dipsw[7:0];
            DIP3:    rd_byte = dipsw[23:16];
            IMUX:    rd_byte = cabinet;
            VEC:     rd_byte = vec_dout;
            // open bus floats high
            default: rd_byte = 8'hff;
        endcase
    end

    // Data bus is held between reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 8'hff;
        end else if (dec.rd) begin
            cpu_din <= rd_byte;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hdl/roc_pkg.sv
hdl/roc_addr_decode.sv
hdl/roc_read_mux.sv
hdl/roc_ctrl_latch.sv
hdl/roc_irq_gen.sv
hdl/roc_main_bus.sv
tb/roc_checker.sv
tb/roc_tb.sv

// File: run.sh
#!/bin/sh
# Build the bus glue testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module roc_tb -f list.f -o roc_sim \
    && ./obj_dir/roc_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb/roc_checker.sv
//******************************
// Result checker comparing DUT
// outputs with table values
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_checker import roc_pkg::*; (
    input  wire logic         clk,
    input  wire logic         chk,        // sample at the next falling edge
    input  wire logic [  2:0] kind,
    input  wire logic [127:0] name,
    input  wire logic [ 19:0] expected,
    input  wire logic [  7:0] cpu_din,
    input  wire logic [  7:0] snd_latch,
    input  wire logic [  7:0] st_dout,
    input  wire ctrl_t        ctrl,
    input  wire logic         rom_cs,
    input  wire logic         vram_cs,
    input  wire logic         objram_cs,
    input  wire logic         ram_cs,
    input  wire logic [ 15:0] rom_addr,
    input  wire logic         rom_ok,
    input  wire logic         rom_ok_out,
    input  wire logic         irq_n,
    input  wire logic         firq_n,
    output int                errors,
    output int                tests
);

    // Output that a table entry looks at
    localparam logic [2:0] K_DIN = 3'd1;
    localparam logic [2:0] K_ROM = 3'd2;
    localparam logic [2:0] K_SND = 3'd3;
    localparam logic [2:0] K_ST  = 3'd4;
    localparam logic [2:0] K_IRQ = 3'd5;

    int          err_cnt  = 0;
    int          test_cnt = 0;
    logic [19:0] actual;

    assign errors = err_cnt;
    assign tests  = test_cnt;

    always_comb begin
        case (kind)
            K_DIN:   actual = {12'h000, cpu_din};
            K_ROM:   actual = {vram_cs, objram_cs, ram_cs, rom_cs, rom_addr};  // selects and offset
            K_SND:   actual = {12'h000, snd_latch};
            K_ST:    actual = {7'h00, ctrl, st_dout};         // both latch views
            K_IRQ:   actual = {18'd0, irq_n, firq_n};
            default: actual = 20'hfffff;
        endcase
    end

    // Sampled mid-cycle once the registers have settled
    always @(negedge clk) begin
        if (chk) begin
            test_cnt <= test_cnt + 1;
            if (actual !== expected) begin
                err_cnt <= err_cnt + 1;
                $display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
            end else if (rom_ok_out !== rom_ok) begin
                err_cnt <= err_cnt + 1;       // ROM status pass-through
                $display("[ERROR] %0s: rom_ok_out expected %b, actual %b",
                         name, rom_ok, rom_ok_out);
            end else begin
                $display("[PASS] %0s: %h", name, actual);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/roc_tb.sv
//******************************
// Bus glue testbench, memory
// models, stimulus table
//******************************
`timescale 1ns/1ps
`default_nettype none

module roc_tb import roc_pkg::*; ();

    localparam logic [15:0] ROM_BASE = ROM_BASE_DEF;
    localparam int          HOLD     = 8;       // cycles per entry
    localparam int          MAX_TAB  = 48;
    localparam logic [2:0]  K_IDLE   = 3'd0;    // no check
    localparam logic [2:0]  K_DIN    = 3'd1;
    localparam logic [2:0]  K_ROM    = 3'd2;
    localparam logic [2:0]  K_SND    = 3'd3;
    localparam logic [2:0]  K_ST     = 3'd4;
    localparam logic [2:0]  K_IRQ    = 3'd5;
    localparam logic        RD       = 1'b1;
    localparam logic        WR       = 1'b0;
    localparam logic        HI       = 1'b1;
    localparam logic        LO       = 1'b0;

    logic         clk = 1'b0;
    logic         rst;
    bus_req_t     bus;
    logic         lvbl;
    logic         dip_pause;
    logic         rom_ok;
    cab_t         cab;
    logic [23:0]  dipsw;
    logic [ 7:0]  rom_data, vram_dout, obj_dout, ram_dout;
    logic [15:0]  rom_addr;
    logic         rom_cs, vram_cs, objram_cs, ram_cs;
    logic [ 7:0]  cpu_din, snd_latch, st_dout;
    ctrl_t        ctrl;
    logic         irq_n, firq_n, rom_ok_out;

    // Stimulus table
    logic [127:0] tab_name  [MAX_TAB];
    bus_req_t     tab_bus   [MAX_TAB];
    logic [  2:0] tab_kind  [MAX_TAB];
    logic         tab_lvbl  [MAX_TAB];
    logic         tab_pause [MAX_TAB];
    logic [ 19:0] tab_exp   [MAX_TAB];
    int           n_tab = 0;
    int           n_chk = 0;     // entries that carry a check

    logic         chk;
    logic [  2:0] cur_kind;
    logic [127:0] cur_name;
    logic [ 19:0] cur_exp;
    int           errors;
    int           tests;
    int           cycles = 0;
    int           limit  = 0;
    integer       seed   = 32'hf167_a2c4;

    always #10 clk = ~clk;

    // Memory models
    assign rom_data  = rom_addr[7:0] ^ 8'ha5;
    assign vram_dout = bus.addr[7:0] + 8'd1;
    assign obj_dout  = bus.addr[7:0] + 8'd2;
    assign ram_dout  = bus.addr[7:0] + 8'd3;

    roc_main_bus #(.ROM_BASE(ROM_BASE)) dut_i (
        .clk(clk), .rst(rst), .bus(bus), .cpu_din(cpu_din),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .rom_ok(rom_ok), .rom_ok_out(rom_ok_out),
        .vram_cs(vram_cs), .objram_cs(objram_cs), .ram_cs(ram_cs),
        .vram_dout(vram_dout), .obj_dout(obj_dout), .ram_dout(ram_dout),
        .cab(cab), .dipsw(dipsw), .dip_pause(dip_pause),
        .snd_latch(snd_latch), .ctrl(ctrl), .st_dout(st_dout),
        .lvbl(lvbl), .irq_n(irq_n), .firq_n(firq_n)
    );

    roc_checker chk_i (
        .clk(clk), .chk(chk), .kind(cur_kind), .name(cur_name), .expected(cur_exp),
        .cpu_din(cpu_din), .snd_latch(snd_latch), .st_dout(st_dout), .ctrl(ctrl),
        .rom_cs(rom_cs), .vram_cs(vram_cs), .objram_cs(objram_cs), .ram_cs(ram_cs),
        .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_ok_out(rom_ok_out),
        .irq_n(irq_n), .firq_n(firq_n), .errors(errors), .tests(tests)
    );

    function automatic logic [19:0] din(input logic [7:0] b);
        return {12'h000, b};
    endfunction

    // Selects in order vram, obj, ram, rom, then the ROM offset
    function automatic logic [19:0] rom_exp(input logic [3:0] cs, input logic [15:0] off);
        return {cs, off};
    endfunction

    // Status port order is mute, snd_on, flip, firq, irq
    function automatic logic [19:0] st_exp(input logic [4:0] c);
        return {7'h00, c, 3'b000, c[2], c[3], c[4], c[1], c[0]};
    endfunction

    function automatic logic [19:0] irq_exp(input logic [1:0] lines);
        return {18'd0, lines};      // irq_n, firq_n
    endfunction

    // Pull-ups, buttons, then directions 2,3,0,1
    function automatic logic [7:0] player_byte(input logic [5:0] j);
        return {2'b11, j[5:4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic int check_edge(input logic [2:0] k);
        if (k == K_IDLE) return 0;
        return (k == K_DIN) ? 2 : HOLD - 1;     // reads at their latency
    endfunction

    task automatic add_step(input logic [127:0] nm, input logic [2:0] k,
                            input logic [15:0] a, input logic dir, input logic [7:0] d,
                            input logic lv, input logic pa, input logic [19:0] e);
        tab_name[n_tab]  = nm;
        tab_kind[n_tab]  = k;
        tab_bus[n_tab]   = '{a, dir, 1'b1, 1'b1, d};
        tab_lvbl[n_tab]  = lv;
        tab_pause[n_tab] = pa;
        tab_exp[n_tab]   = e;
        if (k != K_IDLE) n_chk++;
        n_tab++;
    endtask

    // End the run if the table stalls
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the stimulus table did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        bus         = '{16'h0000, RD, 1'b0, 1'b0, 8'h00};
        lvbl        = HI;
        dip_pause   = HI;
        rom_ok      = 1'b1;
        chk         = 1'b0;
        cur_kind    = K_IDLE;
        cur_name    = '0;
        cur_exp     = '0;
        dipsw       = 24'h5a_3c_96;
        cab.start   = 2'b10;
        cab.coin    = 2'b01;
        cab.service = 1'b1;
        cab.joy1    = 6'($random(seed));
        cab.joy2    = 6'($random(seed));

        // Memory read map
        add_step("rom_rd",      K_DIN, 16'h6123, RD, 8'h00, HI, HI, din(8'h23 ^ 8'ha5));
        add_step("vram_rd",     K_DIN, 16'h4812, RD, 8'h00, HI, HI, din(8'h13));
        add_step("obj_rd",      K_DIN, 16'h4034, RD, 8'h00, HI, HI, din(8'h36));
        add_step("ram_rd",      K_DIN, 16'h5a56, RD, 8'h00, HI, HI, din(8'h59));
        add_step("open_rd",     K_DIN, 16'h2000, RD, 8'h00, HI, HI, din(8'hff));
        // ROM select and offset
        add_step("rom_cs_rd",   K_ROM, 16'h7abc, RD, 8'h00, HI, HI, rom_exp(4'b0001, 16'h1abc));
        add_step("rom_cs_wr",   K_ROM, 16'h7abc, WR, 8'h55, HI, HI, rom_exp(4'b0000, 16'h1abc));
        add_step("rom_cs_fff2", K_ROM, 16'hfff2, RD, 8'h00, HI, HI, rom_exp(4'b0000, 16'h9ff2));
        add_step("rom_cs_fffd", K_ROM, 16'hfffd, RD, 8'h00, HI, HI, rom_exp(4'b0000, 16'h9ffd));
        add_step("rom_cs_fffe", K_ROM, 16'hfffe, RD, 8'h00, HI, HI, rom_exp(4'b0001, 16'h9ffe));
        // Memory chip selects
        add_step("vram_cs",     K_ROM, 16'h4812, RD, 8'h00, HI, HI, rom_exp(4'b1000, 16'he812));
        add_step("obj_cs",      K_ROM, 16'h4034, RD, 8'h00, HI, HI, rom_exp(4'b0100, 16'he034));
        add_step("ram_cs",      K_ROM, 16'h5a56, RD, 8'h00, HI, HI, rom_exp(4'b0010, 16'hfa56));
        // I/O page reads
        add_step("dip1_rd",     K_DIN, 16'h8000, RD, 8'h00, HI, HI, din(dipsw[7:0]));
        add_step("dip3_rd",     K_DIN, 16'h8100, RD, 8'h00, HI, HI, din(dipsw[23:16]));
        add_step("imux_sys",    K_DIN, 16'h8080, RD, 8'h00, HI, HI,
                 din({3'b111, cab.start, cab.service, cab.coin}));
        add_step("imux_p1",     K_DIN, 16'h8081, RD, 8'h00, HI, HI, din(player_byte(cab.joy1)));
        add_step("imux_p2",     K_DIN, 16'h8082, RD, 8'h00, HI, HI, din(player_byte(cab.joy2)));
        add_step("imux_dip2",   K_DIN, 16'h8083, RD, 8'h00, HI, HI, din(dipsw[15:8]));
        // Sound latch and output latch
        add_step("snd_wr",      K_SND, 16'h3100, WR, 8'h5c, HI, HI, din(8'h5c));
        add_step("snd_wr2",     K_SND, 16'h3100, WR, 8'ha3, HI, HI, din(8'ha3));
        add_step("oreg_flip",   K_ST,  16'h3080, WR, 8'h01, HI, HI, st_exp(5'b10000));
        add_step("oreg_snd_on", K_ST,  16'h3081, WR, 8'h01, HI, HI, st_exp(5'b11000));
        add_step("oreg_mute",   K_ST,  16'h3082, WR, 8'h01, HI, HI, st_exp(5'b11100));
        add_step("oreg_bit3",   K_ST,  16'h3083, WR, 8'hff, HI, HI, st_exp(5'b11100));
        add_step("oreg_bit4",   K_ST,  16'h3084, WR, 8'hff, HI, HI, st_exp(5'b11100));
        add_step("oreg_bit5",   K_ST,  16'h3085, WR, 8'hff, HI, HI, st_exp(5'b11100));
        add_step("oreg_firq",   K_ST,  16'h3086, WR, 8'h01, HI, HI, st_exp(5'b11110));
        add_step("oreg_irq",    K_ST,  16'h3087, WR, 8'h01, HI, HI, st_exp(5'b11111));
        add_step("oreg_flip_d0", K_ST, 16'h3080, WR, 8'hfe, HI, HI, st_exp(5'b01111));
        // Vector RAM written on the I/O page and read at both windows
        add_step("vec_wr2",     K_IDLE, 16'h3182, WR, 8'h3c, HI, HI, 20'h0);
        add_step("vec_wrd",     K_IDLE, 16'h318d, WR, 8'he7, HI, HI, 20'h0);
        add_step("vec_io2",     K_DIN, 16'h8182, RD, 8'h00, HI, HI, din(8'h3c));
        add_step("vec_iod",     K_DIN, 16'h818d, RD, 8'h00, HI, HI, din(8'he7));
        add_step("vec_fff2",    K_DIN, 16'hfff2, RD, 8'h00, HI, HI, din(8'h3c));
        add_step("vec_fffd",    K_DIN, 16'hfffd, RD, 8'h00, HI, HI, din(8'he7));
        // Interrupts with FIRQ on every second VBL fall
        add_step("vbl_frame1",  K_IRQ, 16'h0000, RD, 8'h00, LO, HI, irq_exp(2'b00));
        add_step("irq_en_off",  K_IRQ, 16'h3087, WR, 8'h00, HI, HI, irq_exp(2'b10));
        add_step("pause_off",   K_IRQ, 16'h0000, RD, 8'h00, HI, LO, irq_exp(2'b11));
        add_step("irq_en_on",   K_IRQ, 16'h3087, WR, 8'h01, HI, HI, irq_exp(2'b11));
        add_step("vbl_frame2",  K_IRQ, 16'h0000, RD, 8'h00, LO, HI, irq_exp(2'b01));
        add_step("vbl_end2",    K_IRQ, 16'h0000, RD, 8'h00, HI, HI, irq_exp(2'b01));
        add_step("vbl_frame3",  K_IRQ, 16'h0000, RD, 8'h00, LO, HI, irq_exp(2'b00));
        add_step("pause_drop",  K_IRQ, 16'h0000, RD, 8'h00, HI, LO, irq_exp(2'b01));
        add_step("irq_release", K_IRQ, 16'h3087, WR, 8'h00, HI, LO, irq_exp(2'b11));
        limit = n_tab * HOLD + 50;

        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < n_tab; i++) begin
            bus       = tab_bus[i];           // 2 ns after the edge
            lvbl      = tab_lvbl[i];
            dip_pause = tab_pause[i];
            rom_ok    = i[0];                 // ROM status toggles per entry
            cur_kind  = tab_kind[i];
            cur_name  = tab_name[i];
            cur_exp   = tab_exp[i];
            for (int c = 1; c <= HOLD; c++) begin
                @(posedge clk);
                #2 chk = (c == check_edge(cur_kind));
            end
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests == n_chk) begin
            $display("Test OK");
        end else begin
            if (tests != n_chk) $display("Only %0d of %0d checks ran", tests, n_chk);
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
